/* common/arm_pkg.sv */
`default_nettype none

package arm_pkg;

    localparam int data_width = 32;
    localparam int reg_addr_width = 4;
    localparam int reg_count = 16;

    // Instruction bits 24:21
    typedef enum logic [3:0] {
        dp_and = 4'b0000,
        dp_eor = 4'b0001,
        dp_sub = 4'b0010,
        dp_rsb = 4'b0011,
        dp_add = 4'b0100,
        dp_adc = 4'b0101,
        dp_sbc = 4'b0110,
        dp_rsc = 4'b0111,
        dp_tst = 4'b1000,
        dp_teq = 4'b1001,
        dp_cmp = 4'b1010,
        dp_cmn = 4'b1011,
        dp_orr = 4'b1100,
        dp_mov = 4'b1101,
        dp_bic = 4'b1110,
        dp_mvn = 4'b1111
    } dp_opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_adc,
        alu_sub,
        alu_sbc,
        alu_rsb,
        alu_rsc,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b,
        alu_not_b,
        alu_and_not,
        alu_none
    } alu_op_e;

    // Instruction bits 6:5
    typedef enum logic [1:0] {
        shift_lsl = 2'b00,
        shift_lsr = 2'b01,
        shift_asr = 2'b10,
        shift_ror = 2'b11
    } shift_e;

    // Instruction bit 25
    typedef enum logic {
        mode_shifted_reg = 1'b0,
        mode_rotated_imm = 1'b1
    } operand_mode_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                                clk,
    input  logic                                write,
    input  logic [arm_pkg::reg_addr_width-1:0]  write_addr,
    input  logic [arm_pkg::data_width-1:0]      write_data,
    input  logic [arm_pkg::reg_addr_width-1:0]  read_addr_a,
    input  logic [arm_pkg::reg_addr_width-1:0]  read_addr_b,
    output logic [arm_pkg::data_width-1:0]      read_data_a,
    output logic [arm_pkg::data_width-1:0]      read_data_b
);

    // R15 is a plain register here
    logic [arm_pkg::data_width-1:0] regs [arm_pkg::reg_count];

    always_ff @(posedge clk) begin
        if (write) begin
            regs[write_addr] <= write_data;
        end
    end

    // Write-to-read bypass is done by the forwarding muxes in decode
    assign read_data_a = regs[read_addr_a];
    assign read_data_b = regs[read_addr_b];

endmodule

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  logic [arm_pkg::data_width-1:0]      instr,
    output arm_pkg::alu_op_e                    op,
    output arm_pkg::operand_mode_e              mode,
    output logic [arm_pkg::reg_addr_width-1:0]  rn,
    output logic [arm_pkg::reg_addr_width-1:0]  rd,
    output logic [arm_pkg::reg_addr_width-1:0]  rm,
    output logic                                writes,
    output logic                                set_flags
);

    arm_pkg::dp_opcode_e opcode;

    assign opcode = arm_pkg::dp_opcode_e'(instr[24:21]);
    assign mode   = arm_pkg::operand_mode_e'(instr[25]);
    assign rn     = instr[19:16];
    assign rd     = instr[15:12];
    assign rm     = instr[3:0];

    always_comb begin
        op        = arm_pkg::alu_none;
        writes    = 1'b1;
        set_flags = instr[20];
        case (opcode)
            arm_pkg::dp_and: op = arm_pkg::alu_and;
            arm_pkg::dp_eor: op = arm_pkg::alu_xor;
            arm_pkg::dp_sub: op = arm_pkg::alu_sub;
            arm_pkg::dp_rsb: op = arm_pkg::alu_rsb;
            arm_pkg::dp_add: op = arm_pkg::alu_add;
            arm_pkg::dp_adc: op = arm_pkg::alu_adc;
            arm_pkg::dp_sbc: op = arm_pkg::alu_sbc;
            arm_pkg::dp_rsc: op = arm_pkg::alu_rsc;
            arm_pkg::dp_orr: op = arm_pkg::alu_or;
            arm_pkg::dp_mov: op = arm_pkg::alu_pass_b;
            arm_pkg::dp_bic: op = arm_pkg::alu_and_not;
            arm_pkg::dp_mvn: op = arm_pkg::alu_not_b;
            // Test and compare retire as no-ops
            arm_pkg::dp_tst,
            arm_pkg::dp_teq,
            arm_pkg::dp_cmp,
            arm_pkg::dp_cmn: begin
                op        = arm_pkg::alu_none;
                writes    = 1'b0;
                set_flags = 1'b0;
            end
            default: begin
                op        = arm_pkg::alu_none;
                writes    = 1'b0;
                set_flags = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* decode/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_valid,
    input  logic [arm_pkg::data_width-1:0]      instr,
    input  logic [arm_pkg::data_width-1:0]      ex_result,
    input  logic                                wb_write,
    input  logic [arm_pkg::reg_addr_width-1:0]  wb_rd,
    input  logic [arm_pkg::data_width-1:0]      wb_data,
    output logic                                ex_valid,
    output logic                                ex_write,
    output logic                                ex_set_flags,
    output arm_pkg::alu_op_e                    ex_op,
    output arm_pkg::operand_mode_e              ex_mode,
    output logic [arm_pkg::reg_addr_width-1:0]  ex_rd,
    output logic [arm_pkg::data_width-1:0]      ex_a,
    output logic [arm_pkg::data_width-1:0]      ex_rm_value,
    output logic [11:0]                         ex_shift_field
);

    arm_pkg::alu_op_e               op;
    arm_pkg::operand_mode_e         mode;
    logic [arm_pkg::reg_addr_width-1:0] rn;
    logic [arm_pkg::reg_addr_width-1:0] rd;
    logic [arm_pkg::reg_addr_width-1:0] rm;
    logic                           writes;
    logic                           set_flags;
    logic [arm_pkg::data_width-1:0] rn_file;
    logic [arm_pkg::data_width-1:0] rm_file;
    logic [arm_pkg::data_width-1:0] rn_value;
    logic [arm_pkg::data_width-1:0] rm_value;

    instr_decoder decoder_i (
        .instr     (instr),
        .op        (op),
        .mode      (mode),
        .rn        (rn),
        .rd        (rd),
        .rm        (rm),
        .writes    (writes),
        .set_flags (set_flags)
    );

    reg_file reg_file_i (
        .clk         (clk),
        .write       (wb_write),
        .write_addr  (wb_rd),
        .write_data  (wb_data),
        .read_addr_a (rn),
        .read_addr_b (rm),
        .read_data_a (rn_file),
        .read_data_b (rm_file)
    );

    // Execute beats writeback, file otherwise
    assign rn_value = (ex_write && ex_rd == rn) ? ex_result :
                      (wb_write && wb_rd == rn) ? wb_data : rn_file;
    assign rm_value = (ex_write && ex_rd == rm) ? ex_result :
                      (wb_write && wb_rd == rm) ? wb_data : rm_file;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            ex_write     <= 1'b0;
            ex_set_flags <= 1'b0;
        end else begin
            ex_valid     <= instr_valid;
            ex_write     <= instr_valid && writes;
            ex_set_flags <= instr_valid && set_flags;
        end
    end

    always_ff @(posedge clk) begin
        ex_op          <= op;
        ex_mode        <= mode;
        ex_rd          <= rd;
        ex_a           <= rn_value;
        ex_rm_value    <= rm_value;
        ex_shift_field <= instr[11:0];
    end

endmodule

`default_nettype wire

/* execute/barrel_shifter.sv */
`timescale 1ns/1ns
`default_nettype none

module barrel_shifter (
    input  arm_pkg::operand_mode_e              mode,
    input  logic [arm_pkg::data_width-1:0]      rm_value,
    input  logic [11:0]                         shift_field,
    output logic [arm_pkg::data_width-1:0]      operand
);

    arm_pkg::shift_e                    kind;
    logic [4:0]                         amount;
    logic [4:0]                         rot_amount;
    logic [arm_pkg::data_width-1:0]     imm;
    logic [2*arm_pkg::data_width-1:0]   imm_rot;
    logic [2*arm_pkg::data_width-1:0]   rm_rot;
    logic [arm_pkg::data_width-1:0]     shifted;

    assign kind       = arm_pkg::shift_e'(shift_field[6:5]);
    assign amount     = shift_field[11:7];
    assign rot_amount = {shift_field[11:8], 1'b0}; // Twice the rotate field
    assign imm        = {{(arm_pkg::data_width-8){1'b0}}, shift_field[7:0]};

    // Rotate right by shifting a doubled copy
    assign imm_rot = {imm, imm} >> rot_amount;
    assign rm_rot  = {rm_value, rm_value} >> amount;

    // Amount zero passes Rm through for every kind
    always_comb begin
        case (kind)
            arm_pkg::shift_lsl: shifted = rm_value << amount;
            arm_pkg::shift_lsr: shifted = rm_value >> amount;
            arm_pkg::shift_asr: shifted = $signed(rm_value) >>> amount;
            arm_pkg::shift_ror: shifted = rm_rot[arm_pkg::data_width-1:0];
            default:            shifted = rm_value;
        endcase
    end

    assign operand = (mode == arm_pkg::mode_rotated_imm) ?
                     imm_rot[arm_pkg::data_width-1:0] : shifted;

endmodule

`default_nettype wire

/* execute/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  arm_pkg::alu_op_e                op,
    input  logic [arm_pkg::data_width-1:0]  a,
    input  logic [arm_pkg::data_width-1:0]  b,
    input  logic                            carry_in,
    output logic [arm_pkg::data_width-1:0]  result,
    output arm_pkg::flags_t                 flags
);

    localparam int msb = arm_pkg::data_width - 1;

    logic [msb:0]   add_x;
    logic [msb:0]   add_y;
    logic           add_cin;
    logic [msb+1:0] sum;
    logic           arith;

    // One adder, subtraction as x + ~y + cin
    always_comb begin
        add_x   = a;
        add_y   = b;
        add_cin = 1'b0;
        arith   = 1'b1;
        case (op)
            arm_pkg::alu_add: add_cin = 1'b0;
            arm_pkg::alu_adc: add_cin = carry_in;
            arm_pkg::alu_sub: begin
                add_y   = ~b;
                add_cin = 1'b1;
            end
            arm_pkg::alu_sbc: begin
                add_y   = ~b;
                add_cin = carry_in; // Borrow is the inverted carry
            end
            arm_pkg::alu_rsb: begin
                add_x   = b;
                add_y   = ~a;
                add_cin = 1'b1;
            end
            arm_pkg::alu_rsc: begin
                add_x   = b;
                add_y   = ~a;
                add_cin = carry_in;
            end
            default: arith = 1'b0;
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + {{msb+1{1'b0}}, add_cin};

    always_comb begin
        case (op)
            arm_pkg::alu_and:     result = a & b;
            arm_pkg::alu_or:      result = a | b;
            arm_pkg::alu_xor:     result = a ^ b;
            arm_pkg::alu_pass_b:  result = b;
            arm_pkg::alu_not_b:   result = ~b;
            arm_pkg::alu_and_not: result = a & ~b;
            arm_pkg::alu_none:    result = '0;
            default:              result = sum[msb:0];
        endcase
    end

    assign flags.n = result[msb];
    assign flags.z = (result == '0);
    assign flags.c = arith && sum[msb+1]; // Set means no borrow on subtracts
    assign flags.v = arith && (add_x[msb] == add_y[msb]) && (sum[msb] != add_x[msb]);

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ex_valid,
    input  logic                                ex_write,
    input  logic                                ex_set_flags,
    input  arm_pkg::alu_op_e                    ex_op,
    input  arm_pkg::operand_mode_e              ex_mode,
    input  logic [arm_pkg::reg_addr_width-1:0]  ex_rd,
    input  logic [arm_pkg::data_width-1:0]      ex_a,
    input  logic [arm_pkg::data_width-1:0]      ex_rm_value,
    input  logic [11:0]                         ex_shift_field,
    output logic [arm_pkg::data_width-1:0]      ex_result,
    output logic                                wb_valid,
    output logic                                wb_write,
    output logic [arm_pkg::reg_addr_width-1:0]  wb_rd,
    output logic [arm_pkg::data_width-1:0]      wb_data,
    output arm_pkg::flags_t                     flags
);

    logic [arm_pkg::data_width-1:0] operand_b;
    arm_pkg::flags_t                alu_flags;

    barrel_shifter shifter_i (
        .mode        (ex_mode),
        .rm_value    (ex_rm_value),
        .shift_field (ex_shift_field),
        .operand     (operand_b)
    );

    alu alu_i (
        .op       (ex_op),
        .a        (ex_a),
        .b        (operand_b),
        .carry_in (flags.c),
        .result   (ex_result),
        .flags    (alu_flags)
    );

    // Holds its value when S is clear
    always_ff @(posedge clk) begin
        if (reset) begin
            flags <= '0;
        end else if (ex_valid && ex_set_flags) begin
            flags <= alu_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_write <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_write <= ex_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

endmodule

`default_nettype wire

/* source/dp_core.sv */
`timescale 1ns/1ns
`default_nettype none

module dp_core (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                instr_valid,
    input  logic [arm_pkg::data_width-1:0]      instr,
    output logic                                wb_valid,
    output logic [arm_pkg::reg_addr_width-1:0]  wb_rd,
    output logic [arm_pkg::data_width-1:0]      wb_data,
    output arm_pkg::flags_t                     flags
);

    logic                               ex_valid;
    logic                               ex_write;
    logic                               ex_set_flags;
    arm_pkg::alu_op_e                   ex_op;
    arm_pkg::operand_mode_e             ex_mode;
    logic [arm_pkg::reg_addr_width-1:0] ex_rd;
    logic [arm_pkg::data_width-1:0]     ex_a;
    logic [arm_pkg::data_width-1:0]     ex_rm_value;
    logic [11:0]                        ex_shift_field;
    logic [arm_pkg::data_width-1:0]     ex_result;
    logic                               wb_write;

    decode_stage decode_i (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .ex_result      (ex_result),
        .wb_write       (wb_write),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .ex_valid       (ex_valid),
        .ex_write       (ex_write),
        .ex_set_flags   (ex_set_flags),
        .ex_op          (ex_op),
        .ex_mode        (ex_mode),
        .ex_rd          (ex_rd),
        .ex_a           (ex_a),
        .ex_rm_value    (ex_rm_value),
        .ex_shift_field (ex_shift_field)
    );

    execute_stage execute_i (
        .clk            (clk),
        .reset          (reset),
        .ex_valid       (ex_valid),
        .ex_write       (ex_write),
        .ex_set_flags   (ex_set_flags),
        .ex_op          (ex_op),
        .ex_mode        (ex_mode),
        .ex_rd          (ex_rd),
        .ex_a           (ex_a),
        .ex_rm_value    (ex_rm_value),
        .ex_shift_field (ex_shift_field),
        .ex_result      (ex_result),
        .wb_valid       (wb_valid),
        .wb_write       (wb_write),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data),
        .flags          (flags)
    );

endmodule

`default_nettype wire

/* tests/dp_core_assert.sv */
`timescale 1ns/1ns
`default_nettype none

module dp_core_assert (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            wb_valid,
    input  logic [arm_pkg::data_width-1:0]  wb_data,
    input  arm_pkg::flags_t                 flags,
    input  logic                            ex_valid,
    input  logic                            ex_set_flags
);

    int failures = 0; // Read by the testbench at the end of the run

    wb_idle_after_reset: assert property (@(posedge clk) reset |=> !wb_valid)
        else begin
            $error("wb_valid high in the cycle after reset");
            failures++;
        end

    wb_data_known: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> !$isunknown(wb_data))
        else begin
            $error("wb_data has unknown bits while wb_valid is high");
            failures++;
        end

    // Flags move only when a flag-setting instruction leaves execute
    flags_hold: assert property (@(posedge clk) disable iff (reset)
        !(ex_valid && ex_set_flags) |=> $stable(flags))
        else begin
            $error("flags changed without a flag-setting instruction");
            failures++;
        end

endmodule

bind dp_core dp_core_assert assert_i (
    .clk          (clk),
    .reset        (reset),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data),
    .flags        (flags),
    .ex_valid     (ex_valid),
    .ex_set_flags (ex_set_flags)
);

`default_nettype wire

/* tests/dp_core_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module dp_core_tb;

    localparam int reset_cycles = 10;
    localparam int issued_slots = 200; // Upper bound over all tests
    localparam int cycle_margin = 4;

    logic                   clk;
    logic                   reset;
    logic                   instr_valid;
    logic [31:0]            instr;
    logic                   wb_valid;
    logic [3:0]             wb_rd;
    logic [31:0]            wb_data;
    arm_pkg::flags_t        flags;

    logic [31:0]            lfsr_state = 32'h47f8f439;
    logic [31:0]            ref_regs [16];
    arm_pkg::flags_t        ref_flags;
    logic [32:0]            prog_q [$]; // {valid, instruction}

    dp_core dut_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .flags       (flags)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_data(input string test, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] wb_data: expected %h, actual %h", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_rd(input string test, input logic [3:0] expected,
                              input logic [3:0] actual);
        if (actual !== expected) begin
            $display("** Error [%s] wb_rd: expected %0d, actual %0d", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic compare_flags(input string test, input arm_pkg::flags_t expected,
                                 input arm_pkg::flags_t actual);
        if (actual !== expected) begin
            $display("** Error [%s] flags nzcv: expected %b, actual %b", test, expected, actual);
            abort_run();
        end
    endtask

    // Galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        repeat (count) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h80200003 : 32'h0);
        end
        return value;
    endfunction

    function automatic logic [31:0] encode_imm(arm_pkg::dp_opcode_e op, logic s, logic [3:0] rn,
                                               logic [3:0] rd, logic [3:0] rot, logic [7:0] imm);
        return {4'he, 2'b00, 1'b1, op, s, rn, rd, rot, imm};
    endfunction

    function automatic logic [31:0] encode_reg(arm_pkg::dp_opcode_e op, logic s, logic [3:0] rn,
                                               logic [3:0] rd, logic [4:0] amount,
                                               arm_pkg::shift_e kind, logic [3:0] rm);
        return {4'he, 2'b00, 1'b0, op, s, rn, rd, amount, kind, 1'b0, rm};
    endfunction

    function automatic logic [31:0] rotate_right(input logic [31:0] value, input int amount);
        if (amount == 0) return value;
        return (value >> amount) | (value << (32 - amount));
    endfunction

    function automatic logic [31:0] model_operand(input logic [31:0] word,
                                                  input logic [31:0] rm_val);
        int amount;
        if (word[25]) return rotate_right({24'h0, word[7:0]}, 2 * word[11:8]);
        amount = word[11:7];
        if (amount == 0) return rm_val;
        case (word[6:5])
            2'b00:   return rm_val << amount;
            2'b01:   return rm_val >> amount;
            2'b10:   return $signed(rm_val) >>> amount;
            default: return rotate_right(rm_val, amount);
        endcase
    endfunction

    // Architectural result of one instruction, applied to the reference state
    task automatic model_exec(input logic [31:0] word, output logic write,
                              output logic [3:0] rd, output logic [31:0] data);
        arm_pkg::dp_opcode_e opcode;
        logic [31:0]         a;
        logic [31:0]         b;
        logic [32:0]         wide;
        logic                nc;
        arm_pkg::flags_t     f;
        opcode = arm_pkg::dp_opcode_e'(word[24:21]);
        rd     = word[15:12];
        a      = ref_regs[word[19:16]];
        b      = model_operand(word, ref_regs[word[3:0]]);
        nc     = !ref_flags.c;
        f      = '0;
        write  = 1'b1;
        case (opcode)
            arm_pkg::dp_and: data = a & b;
            arm_pkg::dp_eor: data = a ^ b;
            arm_pkg::dp_orr: data = a | b;
            arm_pkg::dp_mov: data = b;
            arm_pkg::dp_bic: data = a & ~b;
            arm_pkg::dp_mvn: data = ~b;
            arm_pkg::dp_add, arm_pkg::dp_adc: begin
                wide = {1'b0, a} + {1'b0, b};
                if (opcode == arm_pkg::dp_adc) wide = wide + 33'(ref_flags.c);
                data = wide[31:0];
                f.c  = wide[32];
                f.v  = (a[31] == b[31]) && (data[31] != a[31]);
            end
            arm_pkg::dp_sub, arm_pkg::dp_sbc, arm_pkg::dp_rsb, arm_pkg::dp_rsc: begin
                if (opcode == arm_pkg::dp_rsb || opcode == arm_pkg::dp_rsc) begin
                    wide = {1'b0, a};
                    a    = b;
                    b    = wide[31:0];
                end
                if (opcode == arm_pkg::dp_sub || opcode == arm_pkg::dp_rsb) nc = 1'b0;
                data = a - b - 32'(nc);
                f.c  = ({1'b0, a} >= {1'b0, b} + 33'(nc)); // No borrow
                f.v  = (a[31] != b[31]) && (data[31] != a[31]);
            end
            default: begin
                data  = '0;
                write = 1'b0;
            end
        endcase
        f.n = data[31];
        f.z = (data == 32'h0);
        if (write) begin
            ref_regs[rd] = data;
            if (word[20]) ref_flags = f;
        end
    endtask

    task automatic issue(input logic [31:0] word);
        prog_q.push_back({1'b1, word});
    endtask

    task automatic bubble(input int count);
        repeat (count) prog_q.push_back({1'b0, 32'h0});
    endtask

    // Builds any word from a MOV and three ORRs with rotated bytes
    task automatic load_value(input logic [3:0] rd, input logic [31:0] value);
        issue(encode_imm(arm_pkg::dp_mov, 1'b0, 4'd0, rd, 4'd0, value[7:0]));
        issue(encode_imm(arm_pkg::dp_orr, 1'b0, rd, rd, 4'd12, value[15:8]));
        issue(encode_imm(arm_pkg::dp_orr, 1'b0, rd, rd, 4'd8, value[23:16]));
        issue(encode_imm(arm_pkg::dp_orr, 1'b0, rd, rd, 4'd4, value[31:24]));
    endtask

    // Streams the queued slots, each result checked two cycles after issue
    task automatic run_program(input string test);
        int                 i;
        int                 n;
        int                 j;
        logic               write;
        logic [3:0]         rd;
        logic [31:0]        data;
        logic               exp_valid [$];
        logic               exp_write [$];
        logic [3:0]         exp_rd [$];
        logic [31:0]        exp_data [$];
        arm_pkg::flags_t    exp_flags [$];
        n = prog_q.size();
        for (i = 0; i < n + 2; i++) begin
            @(posedge clk);
            if (i < n) begin
                instr_valid <= prog_q[i][32];
                instr       <= prog_q[i][31:0];
                write = 1'b0;
                rd    = '0;
                data  = '0;
                if (prog_q[i][32]) model_exec(prog_q[i][31:0], write, rd, data);
                exp_valid.push_back(prog_q[i][32]);
                exp_write.push_back(write);
                exp_rd.push_back(rd);
                exp_data.push_back(data);
                exp_flags.push_back(ref_flags);
            end else begin
                instr_valid <= 1'b0;
            end
            @(negedge clk);
            if (i >= 2) begin
                j = i - 2;
                if (!exp_valid[j] && wb_valid !== 1'b0) begin
                    $display("Error [%s]: wb_valid high in slot %0d with no instruction", test, j);
                    abort_run();
                end
                if (exp_write[j]) begin
                    if (wb_valid !== 1'b1) begin
                        $display("Error [%s]: no writeback for the instruction in slot %0d",
                                 test, j);
                        abort_run();
                    end
                    compare_rd(test, exp_rd[j], wb_rd);
                    compare_data(test, exp_data[j], wb_data);
                end
                compare_flags(test, exp_flags[j], flags);
            end
        end
        prog_q.delete();
    endtask

    task automatic test_mov_imm();
        issue(encode_imm(arm_pkg::dp_mov, 1'b0, 4'd0, 4'd1, 4'd4, 8'hff)); // 0xff000000
        bubble(2);
        issue(encode_imm(arm_pkg::dp_mvn, 1'b0, 4'd0, 4'd2, 4'd1, 8'h3d));
        bubble(2);
        run_program("mov_imm");
    endtask

    task automatic test_add_sub();
        int          i;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] edge_a [4];
        logic [31:0] edge_b [4];
        edge_a = '{32'h7fffffff, 32'hffffffff, 32'h00000000, 32'h80000000};
        edge_b = '{32'h00000001, 32'h00000001, 32'h00000001, 32'h80000000};
        for (i = 0; i < 8; i++) begin
            x = random_bits(32);
            y = random_bits(32);
            if (i >= 4) begin
                x = edge_a[i-4];
                y = edge_b[i-4];
            end
            load_value(4'd3, x);
            load_value(4'd4, y);
            issue(encode_reg(arm_pkg::dp_add, 1'b1, 4'd3, 4'd5, 5'd0, arm_pkg::shift_lsl, 4'd4));
            issue(encode_reg(arm_pkg::dp_sub, 1'b1, 4'd3, 4'd6, 5'd0, arm_pkg::shift_lsl, 4'd4));
        end
        run_program("add_sub");
    endtask

    task automatic test_shifts();
        int          k;
        logic [31:0] x;
        logic [31:0] amount;
        x = random_bits(32);
        load_value(4'd7, x);
        x = random_bits(32);
        load_value(4'd8, x);
        for (k = 0; k < 8; k++) begin
            amount = random_bits(5);
            if (k < 4) amount = '0; // Zero once per kind
            issue(encode_reg(arm_pkg::dp_orr, 1'b0, 4'd8, 4'd9, amount[4:0],
                             arm_pkg::shift_e'(k[1:0]), 4'd7));
            issue(encode_reg(arm_pkg::dp_eor, 1'b1, 4'd8, 4'd10, amount[4:0],
                             arm_pkg::shift_e'(k[1:0]), 4'd7));
        end
        run_program("shifts");
    endtask

    task automatic test_forwarding();
        int          gap;
        logic [31:0] x;
        for (gap = 0; gap < 3; gap++) begin
            x = random_bits(8);
            issue(encode_imm(arm_pkg::dp_mov, 1'b0, 4'd0, 4'd1, 4'd0, x[7:0]));
            bubble(gap);
            issue(encode_reg(arm_pkg::dp_add, 1'b0, 4'd1, 4'd2, 5'd0, arm_pkg::shift_lsl, 4'd1));
            bubble(gap);
            issue(encode_imm(arm_pkg::dp_sub, 1'b0, 4'd2, 4'd3, 4'd0, 8'd1));
        end
        run_program("forwarding");
    endtask

    task automatic test_carry_ops();
        int                  i;
        logic [31:0]         x;
        logic [31:0]         y;
        arm_pkg::dp_opcode_e first_op;
        for (i = 0; i < 4; i++) begin
            x = random_bits(32);
            y = random_bits(32);
            first_op = arm_pkg::dp_add;
            if (i[0]) first_op = arm_pkg::dp_sub;
            load_value(4'd3, x);
            load_value(4'd4, y);
            issue(encode_reg(first_op, 1'b1, 4'd3, 4'd5, 5'd0, arm_pkg::shift_lsl, 4'd4));
            issue(encode_reg(arm_pkg::dp_adc, 1'b0, 4'd3, 4'd6, 5'd0, arm_pkg::shift_lsl, 4'd4));
            issue(encode_reg(arm_pkg::dp_sbc, 1'b1, 4'd3, 4'd7, 5'd0, arm_pkg::shift_lsl, 4'd4));
            issue(encode_reg(arm_pkg::dp_rsc, 1'b1, 4'd3, 4'd8, 5'd0, arm_pkg::shift_lsl, 4'd4));
        end
        run_program("carry_ops");
    endtask

    task automatic test_no_flag_change();
        logic [31:0] x;
        x = random_bits(32);
        load_value(4'd11, x);
        issue(encode_reg(arm_pkg::dp_add, 1'b1, 4'd11, 4'd12, 5'd0, arm_pkg::shift_lsl, 4'd11));
        // Zero result, so its flags would differ from the ADDS ones
        issue(encode_reg(arm_pkg::dp_sub, 1'b0, 4'd11, 4'd13, 5'd0, arm_pkg::shift_lsl, 4'd11));
        issue(encode_reg(arm_pkg::dp_cmp, 1'b1, 4'd11, 4'd12, 5'd0, arm_pkg::shift_lsl, 4'd11));
        issue(encode_imm(arm_pkg::dp_tst, 1'b1, 4'd11, 4'd12, 4'd0, 8'h00));
        issue(encode_reg(arm_pkg::dp_mov, 1'b0, 4'd0, 4'd14, 5'd0, arm_pkg::shift_lsl, 4'd12));
        issue(encode_reg(arm_pkg::dp_orr, 1'b0, 4'd11, 4'd15, 5'd3, arm_pkg::shift_ror, 4'd13));
        run_program("no_flag_change");
    endtask

    always @(negedge clk) begin
        if (dut_i.assert_i.failures != 0) begin
            $display("Error: a bound assertion on the core failed");
            abort_run();
        end
    end

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        ref_flags   = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        test_mov_imm();
        test_add_sub();
        test_shifts();
        test_forwarding();
        test_carry_ops();
        test_no_flag_change();
        @(posedge clk);
        if (dut_i.assert_i.failures == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Error: %0d assertion failures", dut_i.assert_i.failures);
            abort_run();
        end
    end

    initial begin
        repeat (reset_cycles + issued_slots * cycle_margin) @(posedge clk);
        $display("Error: watchdog expired before the tests finished");
        abort_run();
    end

endmodule

`default_nettype wire

/* filelist.f */
common/arm_pkg.sv
source/reg_file.sv
decode/instr_decoder.sv
decode/decode_stage.sv
execute/barrel_shifter.sv
execute/alu.sv
execute/execute_stage.sv
source/dp_core.sv
tests/dp_core_assert.sv
tests/dp_core_tb.sv
